// File: rtl/periph_pkg.sv
// Peripheral package
// Bus widths, the APB slot map and register offsets shared by
// the UART, the machine timer and the APB splitter.

`default_nettype none

package periph_pkg;

	// bus and data widths
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [7:0]  uart_byte_t;
	typedef logic [63:0] mtime_t;

	// ----------------------------------------
	// address map, slot from paddr[15:14]
	typedef logic [1:0] slot_t;
	localparam slot_t SLOT_TIMER = 2'd0;
	localparam slot_t SLOT_UART  = 2'd1;

	// ----------------------------------------
	// uart register offsets
	typedef logic [3:0] uart_off_t;
	localparam uart_off_t UART_STATUS = 4'h0;
	localparam uart_off_t UART_TXDATA = 4'h4;
	localparam uart_off_t UART_RXDATA = 4'h8;
	localparam uart_off_t UART_IRQ_EN = 4'hc;

	// timer register offsets
	typedef logic [4:0] timer_off_t;
	localparam timer_off_t TIMER_MTIME_LO = 5'h00;
	localparam timer_off_t TIMER_MTIME_HI = 5'h04;
	localparam timer_off_t TIMER_CMP_LO   = 5'h08;
	localparam timer_off_t TIMER_CMP_HI   = 5'h0c;
	localparam timer_off_t TIMER_CTRL     = 5'h10;

endpackage

`default_nettype wire

// File: rtl/apb_splitter.sv
// APB address splitter
// Decodes the top two address bits into the timer slot, the UART
// slot or an unmapped slot, and builds the completer response.
// No wait states, so pready follows the access cycle.

`timescale 1ns/1ps
`default_nettype none

module apb_splitter (
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,

	input  periph_pkg::apb_data_t timer_rdata,
	input  periph_pkg::apb_data_t uart_rdata,
	input  logic                  uart_err,

	output logic                  timer_sel,
	output logic                  uart_sel,

	output periph_pkg::apb_data_t prdata,
	output logic                  pready,
	output logic                  pslverr
);

	import periph_pkg::*;

	slot_t slot;
	logic  unmapped;

	assign slot = paddr[$bits(apb_addr_t)-1 -: $bits(slot_t)];

	// ----------------------------------------
	// select decode
	assign timer_sel = psel && (slot == SLOT_TIMER);
	assign uart_sel  = psel && (slot == SLOT_UART);
	assign unmapped  = psel && !timer_sel && !uart_sel;

	// ----------------------------------------
	// response
	assign pready = psel && penable;

	// unmapped slots always error, uart errors on a full fifo
	assign pslverr = pready && (unmapped || uart_err);

	// read data only on reads, zero otherwise
	always_comb begin
		prdata = '0;
		if (!pwrite) begin
			case (slot)
				SLOT_TIMER: prdata = timer_rdata;
				SLOT_UART:  prdata = uart_rdata;
				default:    prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
// UART register block
// APB registers of the mini UART: transmit FIFO feeding the
// transmitter, a single receive holding register with overrun,
// status, interrupt enables and the registered interrupt.

`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
	parameter int TX_FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   sel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  periph_pkg::apb_addr_t  paddr,
	input  periph_pkg::apb_data_t  pwdata,
	output periph_pkg::apb_data_t  rdata,
	output logic                   err,

	output logic                   tx_valid,
	output periph_pkg::uart_byte_t tx_byte,
	input  logic                   tx_ready,

	input  logic                   rx_strobe,
	input  periph_pkg::uart_byte_t rx_byte,

	output logic                   irq
);

	import periph_pkg::*;

	// depth must be a power of two, at least 2
	localparam int PTR_W = $clog2(TX_FIFO_DEPTH);

	uart_off_t  off;
	logic       wr_en;
	logic       rd_en;

	uart_byte_t fifo_mem [TX_FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic       tx_full;
	logic       tx_empty;
	logic       push;
	logic       pop;

	uart_byte_t rx_data;
	logic       rx_valid;
	logic       rx_overrun;
	logic       rx_pop;
	logic       rx_load;
	logic [1:0] irq_en;

	assign off   = paddr[3:0];
	assign wr_en = sel && penable && pwrite;
	assign rd_en = sel && penable && !pwrite;

	// ----------------------------------------
	// transmit fifo
	assign tx_empty = (wr_ptr == rd_ptr);
	assign tx_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	assign push     = wr_en && (off == UART_TXDATA) && !tx_full;
	assign pop      = tx_valid && tx_ready;
	assign err      = wr_en && (off == UART_TXDATA) && tx_full;
	assign tx_valid = !tx_empty;
	assign tx_byte  = fifo_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (push)
			fifo_mem[wr_ptr[PTR_W-1:0]] <= pwdata[7:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// ----------------------------------------
	// receive holding register
	assign rx_pop  = rd_en && (off == UART_RXDATA);
	// a byte arriving while the old one is still unread is lost
	assign rx_load = rx_strobe && (!rx_valid || rx_pop);

	always_ff @(posedge clk) begin
		if (rx_load)
			rx_data <= rx_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
			irq_en     <= 2'b00;
			irq        <= 1'b0;
		end else begin
			if (rx_pop) begin
				rx_valid   <= 1'b0;
				rx_overrun <= 1'b0;
			end
			if (rx_load)
				rx_valid <= 1'b1;
			else if (rx_strobe)
				rx_overrun <= 1'b1;
			if (wr_en && (off == UART_IRQ_EN))
				irq_en <= pwdata[1:0];
			irq <= (rx_valid && irq_en[0]) || (tx_empty && irq_en[1]);
		end
	end

	// ----------------------------------------
	// read mux
	always_comb begin
		case (off)
			UART_STATUS: rdata = {28'd0, rx_overrun, rx_valid, tx_empty, tx_full};
			UART_RXDATA: rdata = rx_valid ? {24'd0, rx_data} : '0;
			UART_IRQ_EN: rdata = {30'd0, irq_en};
			default:     rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
// UART transmitter
// Takes one byte per valid/ready handshake and sends it as an 8N1
// frame, LSB first, CLK_DIV clocks per bit.

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLK_DIV = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   tx_valid,
	input  periph_pkg::uart_byte_t tx_byte,
	output logic                   tx_ready,
	output logic                   tx
);

	import periph_pkg::*;

	localparam int CNT_W = $clog2(CLK_DIV);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t  state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic       bit_end;

	assign tx_ready = (state == TX_IDLE);
	assign bit_end  = (cnt == CNT_W'(CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
			case (state)
				TX_IDLE: if (tx_valid) begin
					// start bit goes out on the next cycle
					shift <= tx_byte;
					tx    <= 1'b0;
					state <= TX_START;
				end
				TX_START: if (bit_end) begin
					tx      <= shift[0];
					shift   <= shift >> 1;
					bit_idx <= '0;
					state   <= TX_DATA;
				end
				TX_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						tx    <= 1'b1;
						state <= TX_STOP;
					end else begin
						tx      <= shift[0];
						shift   <= shift >> 1;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: if (bit_end)
					state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
// UART receiver
// Two-flop synchroniser on the line, start bit confirmed at half a
// period, data sampled at mid-bit. Good frames are reported with a
// one-cycle strobe at the middle of the stop bit.

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLK_DIV = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rx,
	output logic                   rx_strobe,
	output periph_pkg::uart_byte_t rx_byte
);

	import periph_pkg::*;

	localparam int CNT_W = $clog2(CLK_DIV);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t  state;
	logic       rx_meta;
	logic       rx_sync;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic       half_end;
	logic       bit_end;

	assign half_end = (cnt == CNT_W'(CLK_DIV / 2 - 1));
	assign bit_end  = (cnt == CNT_W'(CLK_DIV - 1));

	// shift register holds the last byte through the stop bit
	assign rx_byte = shift;

	// ----------------------------------------
	// line synchroniser
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// ----------------------------------------
	// frame state machine
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= RX_IDLE;
			cnt       <= '0;
			bit_idx   <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			cnt       <= cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: if (half_end) begin
					cnt     <= '0;
					bit_idx <= '0;
					// glitch shorter than half a bit
					state   <= rx_sync ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (bit_end) begin
					cnt     <= '0;
					shift   <= {rx_sync, shift[7:1]};
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				default: if (bit_end) begin
					// framing error drops the byte
					rx_strobe <= rx_sync;
					state     <= RX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/mtimer.sv
// Machine timer
// 64-bit free-running mtime with a 64-bit compare, both written
// as 32-bit halves over APB. The interrupt is registered and only
// raised while counting is enabled.

`timescale 1ns/1ps
`default_nettype none

module mtimer (
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  sel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::apb_data_t pwdata,
	output periph_pkg::apb_data_t rdata,

	output logic                  irq
);

	import periph_pkg::*;

	timer_off_t off;
	logic       wr_en;
	logic       ctrl_wr;
	logic       en_next;
	mtime_t     mtime;
	mtime_t     cmp;
	logic       en;

	assign off     = paddr[4:0];
	assign wr_en   = sel && penable && pwrite;
	assign ctrl_wr = wr_en && (off == TIMER_CTRL);

	// enable as it will be after this edge
	assign en_next = ctrl_wr ? pwdata[0] : en;

	// ----------------------------------------
	// counter, compare and control
	always_ff @(posedge clk) begin
		if (rst) begin
			mtime <= '0;
			cmp   <= '1;
			en    <= 1'b0;
			irq   <= 1'b0;
		end else begin
			if (wr_en && off == TIMER_MTIME_LO)
				mtime <= {mtime[63:32], pwdata};
			else if (wr_en && off == TIMER_MTIME_HI)
				mtime <= {pwdata, mtime[31:0]};
			else if (en)
				mtime <= mtime + 1'b1;

			if (wr_en && off == TIMER_CMP_LO)
				cmp[31:0] <= pwdata;
			if (wr_en && off == TIMER_CMP_HI)
				cmp[63:32] <= pwdata;

			if (ctrl_wr)
				en <= pwdata[0];

			irq <= en_next && (mtime >= cmp);
		end
	end

	// ----------------------------------------
	// read mux
	always_comb begin
		case (off)
			TIMER_MTIME_LO: rdata = mtime[31:0];
			TIMER_MTIME_HI: rdata = mtime[63:32];
			TIMER_CMP_LO:   rdata = cmp[31:0];
			TIMER_CMP_HI:   rdata = cmp[63:32];
			TIMER_CTRL:     rdata = {31'd0, en};
			default:        rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/periph_top.sv
// APB peripheral block
// APB completer port split between a machine timer and a mini UART.
// Both interrupts leave the block as outputs.

`timescale 1ns/1ps
`default_nettype none

module periph_top #(
	parameter int CLK_DIV       = 8,
	parameter int TX_FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,

	// apb completer
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  periph_pkg::apb_addr_t paddr,
	input  periph_pkg::apb_data_t pwdata,
	output periph_pkg::apb_data_t prdata,
	output logic                  pready,
	output logic                  pslverr,

	// serial line and interrupts
	input  logic                  uart_rx,
	output logic                  uart_tx,
	output logic                  uart_irq,
	output logic                  timer_irq
);

	import periph_pkg::*;

	logic       timer_sel;
	logic       uart_sel;
	apb_data_t  timer_rdata;
	apb_data_t  uart_rdata;
	logic       uart_err;

	logic       tx_valid;
	logic       tx_ready;
	uart_byte_t tx_byte;
	logic       rx_strobe;
	uart_byte_t rx_byte;

	apb_splitter splitter_u (
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.timer_rdata (timer_rdata),
		.uart_rdata  (uart_rdata),
		.uart_err    (uart_err),
		.timer_sel   (timer_sel),
		.uart_sel    (uart_sel),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr)
	);

	uart_regs #(
		.TX_FIFO_DEPTH (TX_FIFO_DEPTH)
	) uart_regs_u (
		.clk       (clk),
		.rst       (rst),
		.sel       (uart_sel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.rdata     (uart_rdata),
		.err       (uart_err),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready),
		.rx_strobe (rx_strobe),
		.rx_byte   (rx_byte),
		.irq       (uart_irq)
	);

	uart_tx #(
		.CLK_DIV (CLK_DIV)
	) uart_tx_u (
		.clk      (clk),
		.rst      (rst),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.tx_ready (tx_ready),
		.tx       (uart_tx)
	);

	uart_rx #(
		.CLK_DIV (CLK_DIV)
	) uart_rx_u (
		.clk       (clk),
		.rst       (rst),
		.rx        (uart_rx),
		.rx_strobe (rx_strobe),
		.rx_byte   (rx_byte)
	);

	mtimer timer_u (
		.clk     (clk),
		.rst     (rst),
		.sel     (timer_sel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.rdata   (timer_rdata),
		.irq     (timer_irq)
	);

endmodule

`default_nettype wire

// File: verif/periph_assertions.sv
// APB and interrupt assertions
// Bound into the peripheral top level: completer handshake, UART line
// idle level and timer interrupt gating.

`timescale 1ns/1ps
`default_nettype none

module periph_assertions (
	input logic                  clk,
	input logic                  rst,
	input logic                  psel,
	input logic                  penable,
	input logic                  pwrite,
	input periph_pkg::apb_addr_t paddr,
	input logic                  pready,
	input logic                  tx_idle,
	input logic                  uart_tx,
	input logic                  timer_en,
	input logic                  timer_irq
);

	// ----------------------------------------
	// apb handshake
	// an access cycle is the one right after its setup cycle
	ready_in_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> (psel && penable && $past(psel && !penable)))
		else $error("pready high outside an access cycle");

	// setup is followed by its access cycle, same address and direction
	setup_to_access: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite)))
		else $error("psel, paddr or pwrite changed between setup and access");

	// ----------------------------------------
	// line and interrupts
	line_idle_high: assert property (@(posedge clk) disable iff (rst)
		tx_idle |-> uart_tx)
		else $error("uart_tx low while the transmitter is idle");

	timer_irq_gated: assert property (@(posedge clk) disable iff (rst)
		!timer_en |-> !timer_irq)
		else $error("timer_irq high while the timer is disabled");

endmodule

bind periph_top periph_assertions asserts_u (
	.clk       (clk),
	.rst       (rst),
	.psel      (psel),
	.penable   (penable),
	.pwrite    (pwrite),
	.paddr     (paddr),
	.pready    (pready),
	.tx_idle   (tx_ready),
	.uart_tx   (uart_tx),
	.timer_en  (timer_u.en),
	.timer_irq (timer_irq)
);

`default_nettype wire

// File: verif/tb_periph_top.sv
// Testbench for the APB peripheral block
// Drives APB transfers and the UART receive line, rebuilds frames from
// the UART transmit line and checks both against a reference model of
// the FIFO, the receive holding register, the interrupts and the timer.

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

	import periph_pkg::*;

	localparam int CLK_DIV       = 8;
	localparam int TX_FIFO_DEPTH = 4;
	localparam int FRAME_CYC     = 10 * CLK_DIV;
	// tx frames of test 2, rx frames of test 3, three frames per round of test 4
	localparam int RUN_FRAMES    = 20 + 6 + 12;
	localparam int WATCHDOG_NS   = (RUN_FRAMES * FRAME_CYC + 4000) * 10;
	localparam apb_addr_t UART_BASE  = 16'h4000;
	localparam apb_addr_t TIMER_BASE = 16'h0000;

	logic       clk;
	logic       rst;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_addr_t  paddr;
	apb_data_t  pwdata;
	apb_data_t  prdata;
	logic       pready;
	logic       pslverr;
	logic       uart_rx;
	logic       uart_tx;
	logic       uart_irq;
	logic       timer_irq;

	logic [31:0] rng_state = 32'd17514;
	int          checks;
	int          errors;

	// bytes rebuilt from uart_tx, and bytes the model expects there
	uart_byte_t  line_q[$];
	uart_byte_t  exp_q[$];

	// receive side and interrupt model
	logic        m_rx_valid;
	logic        m_overrun;
	uart_byte_t  m_rx_byte;
	logic [1:0]  m_irq_en;
	logic        m_tx_pending;
	logic        m_tx_full;

	periph_top #(
		.CLK_DIV       (CLK_DIV),
		.TX_FIFO_DEPTH (TX_FIFO_DEPTH)
	) dut (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx),
		.uart_irq  (uart_irq),
		.timer_irq (timer_irq)
	);

	always #5 clk = ~clk;

	// ----------------------------------------
	// helpers

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic apb_data_t status_model();
		return {28'd0, m_overrun, m_rx_valid, !m_tx_pending, m_tx_full};
	endfunction

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %0d %s: pass", num, name);
		else
			$display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
	endtask

	// setup cycle, then access cycle; response sampled inside the access cycle
	task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		rdata = prdata;
		err   = pslverr;
		if (!pready)
			report_error("pready low in the access cycle");
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		apb_transfer(1'b1, addr, data, rd, err);
		check_eq("pslverr", 1'b0, err);
	endtask

	task automatic read_check(input string name, input apb_addr_t addr, input apb_data_t exp);
		apb_data_t rd;
		logic      err;
		apb_transfer(1'b0, addr, 32'd0, rd, err);
		check_eq(name, exp, rd);
		check_eq("pslverr", 1'b0, err);
	endtask

	task automatic read_mtime(output mtime_t t);
		apb_data_t lo;
		apb_data_t hi;
		logic      err;
		apb_transfer(1'b0, TIMER_BASE | TIMER_MTIME_LO, 32'd0, lo, err);
		apb_transfer(1'b0, TIMER_BASE | TIMER_MTIME_HI, 32'd0, hi, err);
		t = {hi, lo};
	endtask

	// one 8N1 frame on uart_rx, then the model takes the byte
	task automatic send_frame(input uart_byte_t b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			uart_rx = bits[i];
			repeat (CLK_DIV) @(negedge clk);
		end
		if (m_rx_valid) begin
			m_overrun = 1'b1;
		end else begin
			m_rx_byte  = b;
			m_rx_valid = 1'b1;
		end
	endtask

	task automatic read_rx_check();
		read_check("prdata RXDATA", UART_BASE | UART_RXDATA,
			m_rx_valid ? {24'd0, m_rx_byte} : 32'd0);
		m_rx_valid = 1'b0;
		m_overrun  = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int waited;
		waited = 0;
		while (line_q.size() < n && waited < (n + 1) * FRAME_CYC) begin
			@(negedge clk);
			waited++;
		end
		if (line_q.size() < n)
			report_error("timed out waiting for frames on uart_tx");
		// rest of the stop bit
		repeat (CLK_DIV) @(negedge clk);
	endtask

	task automatic compare_frames();
		while (exp_q.size() > 0 && line_q.size() > 0)
			check_eq("uart_tx byte", exp_q.pop_front(), line_q.pop_front());
		if (exp_q.size() != 0 || line_q.size() != 0)
			report_error("number of frames on uart_tx differs from the model");
		exp_q.delete();
		line_q.delete();
	endtask

	// irq is registered from state that settles one cycle after a push
	task automatic check_irq();
		repeat (2) @(negedge clk);
		check_eq("uart_irq", (m_rx_valid & m_irq_en[0]) | (!m_tx_pending & m_irq_en[1]),
			uart_irq);
	endtask

	// ----------------------------------------
	// uart_tx line model, sampling at mid-bit
	initial begin : line_monitor
		uart_byte_t b;
		@(negedge rst);
		forever begin
			@(negedge uart_tx);
			repeat (CLK_DIV / 2) @(negedge clk);
			if (uart_tx !== 1'b0)
				report_error("start bit on uart_tx shorter than half a bit");
			for (int i = 0; i < 8; i++) begin
				repeat (CLK_DIV) @(negedge clk);
				b[i] = uart_tx;
			end
			repeat (CLK_DIV) @(negedge clk);
			if (uart_tx !== 1'b1)
				report_error("stop bit on uart_tx is low");
			line_q.push_back(b);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	// ----------------------------------------
	// test sequence
	initial begin : main
		apb_data_t   rd;
		logic        err;
		logic [31:0] r;
		uart_byte_t  b;
		mtime_t      t0;
		mtime_t      t1;
		mtime_t      cmp;
		int          delta;
		int          batch;
		int          accepted;
		int          sent;
		int          waited;
		int          test_err;

		clk          = 1'b0;
		rst          = 1'b1;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		uart_rx      = 1'b1;
		checks       = 0;
		errors       = 0;
		m_rx_valid   = 1'b0;
		m_overrun    = 1'b0;
		m_rx_byte    = '0;
		m_irq_en     = 2'b00;
		m_tx_pending = 1'b0;
		m_tx_full    = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		// reset values, then unmapped slots 2 and 3
		test_err = errors;
		read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
		read_check("prdata IRQ_EN", UART_BASE | UART_IRQ_EN, 32'd0);
		read_check("prdata CTRL", TIMER_BASE | TIMER_CTRL, 32'd0);
		read_check("prdata MTIME_LO", TIMER_BASE | TIMER_MTIME_LO, 32'd0);
		read_check("prdata MTIME_HI", TIMER_BASE | TIMER_MTIME_HI, 32'd0);
		read_check("prdata CMP_LO", TIMER_BASE | TIMER_CMP_LO, 32'hffff_ffff);
		read_check("prdata CMP_HI", TIMER_BASE | TIMER_CMP_HI, 32'hffff_ffff);
		check_eq("uart_irq", 1'b0, uart_irq);
		check_eq("timer_irq", 1'b0, timer_irq);
		check_eq("uart_tx", 1'b1, uart_tx);
		for (int i = 0; i < 8; i++) begin
			r = xorshift32();
			apb_transfer(r[16], 16'h8000 | r[14:0], xorshift32(), rd, err);
			check_eq("pslverr", 1'b1, err);
			check_eq("prdata", 32'd0, rd);
		end
		report_test(1, "reset values and unmapped slots", test_err);

		// twenty bytes in bursts, overflow bytes rejected
		test_err = errors;
		sent = 0;
		while (sent < 20) begin
			r = xorshift32();
			// every full burst overflows the fifo
			batch = TX_FIFO_DEPTH + 2 + int'(r % 3);
			if (batch > 20 - sent)
				batch = 20 - sent;
			accepted = 0;
			for (int k = 0; k < batch; k++) begin
				r = xorshift32();
				b = r[7:0];
				apb_transfer(1'b1, UART_BASE | UART_TXDATA, {24'd0, b}, rd, err);
				// the idle transmitter takes one byte, the fifo holds the rest
				check_eq("pslverr", accepted > TX_FIFO_DEPTH, err);
				if (accepted <= TX_FIFO_DEPTH) begin
					exp_q.push_back(b);
					accepted++;
				end
				sent++;
			end
			m_tx_pending = accepted > 1;
			m_tx_full    = accepted > TX_FIFO_DEPTH;
			read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
			wait_frames(accepted);
			compare_frames();
			m_tx_pending = 1'b0;
			m_tx_full    = 1'b0;
		end
		report_test(2, "transmit frames and fifo full", test_err);

		// receive path and overrun
		test_err = errors;
		for (int i = 0; i < 4; i++) begin
			r = xorshift32();
			send_frame(r[7:0]);
			read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
			read_rx_check();
		end
		r = xorshift32();
		send_frame(r[7:0]);
		send_frame(r[15:8]);
		read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
		read_rx_check();
		read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
		report_test(3, "receive and overrun", test_err);

		// interrupt rule over every enable setting
		test_err = errors;
		for (int en = 0; en < 4; en++) begin
			m_irq_en = en[1:0];
			write_reg(UART_BASE | UART_IRQ_EN, en);
			check_irq();
			r = xorshift32();
			send_frame(r[7:0]);
			read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
			check_irq();
			exp_q.push_back(r[15:8]);
			write_reg(UART_BASE | UART_TXDATA, {24'd0, r[15:8]});
			check_irq();
			// second byte waits in the fifo behind the first frame
			exp_q.push_back(r[23:16]);
			write_reg(UART_BASE | UART_TXDATA, {24'd0, r[23:16]});
			m_tx_pending = 1'b1;
			check_irq();
			read_rx_check();
			check_irq();
			wait_frames(2);
			compare_frames();
			m_tx_pending = 1'b0;
			read_check("prdata STATUS", UART_BASE | UART_STATUS, status_model());
			check_irq();
		end
		m_irq_en = 2'b00;
		write_reg(UART_BASE | UART_IRQ_EN, 32'd0);
		check_irq();
		report_test(4, "uart interrupt", test_err);

		// timer count and compare
		test_err = errors;
		write_reg(TIMER_BASE | TIMER_CTRL, 32'd1);
		read_check("prdata CTRL", TIMER_BASE | TIMER_CTRL, 32'd1);
		read_mtime(t0);
		for (int i = 0; i < 4; i++) begin
			r = xorshift32();
			repeat (1 + r[3:0]) @(negedge clk);
			read_mtime(t1);
			if (t1 <= t0)
				report_error("mtime did not increase between two reads");
			t0 = t1;
		end
		read_mtime(t0);
		r = xorshift32();
		delta = 20 + int'(r % 200);
		cmp = t0 + 64'(delta);
		write_reg(TIMER_BASE | TIMER_CMP_LO, cmp[31:0]);
		write_reg(TIMER_BASE | TIMER_CMP_HI, cmp[63:32]);
		check_eq("timer_irq", 1'b0, timer_irq);
		waited = 0;
		while (timer_irq !== 1'b1 && waited < delta + 20) begin
			@(negedge clk);
			waited++;
		end
		if (timer_irq !== 1'b1)
			report_error("timer_irq did not rise after mtime reached the compare value");
		read_mtime(t1);
		if (t1 < cmp)
			report_error("mtime read after timer_irq is below the compare value");
		write_reg(TIMER_BASE | TIMER_CTRL, 32'd0);
		check_eq("timer_irq", 1'b0, timer_irq);
		report_test(5, "timer compare", test_err);

		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/periph_pkg.sv
rtl/apb_splitter.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/mtimer.sv
rtl/periph_top.sv
verif/periph_assertions.sv
verif/tb_periph_top.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the peripheral testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top \
	-f flist.f -Mdir obj_dir -o sim_periph > build.log 2>&1 ||
	{ cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_periph > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: run did not finish"; exit 1; }
echo "PASS"
